/* verilog/pctrl_pkg.sv */
/*
 * Platform controller shared definitions
 * Register map, channel layout and reset hold length
 */
package pctrl_pkg;

  // --------------------------------------------------------------------------
  // Channel layout
  // --------------------------------------------------------------------------
  // timer0, timer1, uart0, uart1
  localparam int num_chan = 4;
  localparam int sel_w = 3;
  // Wide enough for the slowest qualifier, 2^7 cycles
  localparam int prescale_w = 7;

  // Reset stretch after the cause goes away
  localparam int reset_hold_cycles = 8;
  localparam int hold_cnt_w = 4;

  // --------------------------------------------------------------------------
  // Register map
  // --------------------------------------------------------------------------
  // Word index from haddr[4:2]
  localparam int reg_idx_w = 3;
  localparam logic [31:0] pctrl_id_value = 32'h5043_0001;
  localparam logic [1:0] hresp_okay = 2'b00;

  typedef logic [num_chan-1:0] chan_mask_t;
  // Channel i sits in bits 3i+2 to 3i
  typedef logic [num_chan-1:0][sel_w-1:0] chan_sel_t;

  typedef enum logic [reg_idx_w-1:0] {
    reg_id         = 3'd0,
    reg_clk_gate   = 3'd1,
    reg_sys_rst_en = 3'd2,
    reg_rst_req    = 3'd3,
    reg_clk_sel    = 3'd4,
    reg_none       = 3'd7
  } reg_op_e;

endpackage

/* verilog/pctrl_if.sv */
/*
 * Internal interfaces of the platform controller
 * Register access strobes and per-channel control levels
 */
`timescale 1ns/1ps

// Bus decode to register block
interface reg_bus_if import pctrl_pkg::*; ();

  logic        wr_en;
  reg_op_e     wr_idx;
  logic [31:0] wr_data;
  reg_op_e     rd_idx;
  logic [31:0] rd_data;

  modport decoder (
    output wr_en, wr_idx, wr_data, rd_idx,
    input  rd_data
  );

  modport regs (
    input  wr_en, wr_idx, wr_data, rd_idx,
    output rd_data
  );

endinterface

// Register block to qualifier and reset logic
interface chan_ctrl_if import pctrl_pkg::*; ();

  chan_mask_t gate_en;
  chan_sel_t  clk_sel;
  chan_mask_t sys_rst_en;
  // Single-cycle request mask
  chan_mask_t rst_req_pulse;
  chan_mask_t busy;

  modport ctrl (
    output gate_en, clk_sel, sys_rst_en, rst_req_pulse,
    input  busy
  );

  modport clk_side (input gate_en, clk_sel);

  modport rst_side (
    input  sys_rst_en, rst_req_pulse,
    output busy
  );

endinterface

/* verilog/pctrl_bus_decode.sv */
/*
 * AHB-Lite slave decode for the platform controller
 * Captures the address phase and issues register strobes
 */
`timescale 1ns/1ps

module pctrl_bus_decode import pctrl_pkg::*; (
  input  logic        master_clk,
  input  logic        rst_n,
  input  logic        hsel,
  input  logic [31:0] haddr,
  input  logic [1:0]  htrans,
  input  logic        hwrite,
  input  logic        hready,
  input  logic [31:0] hwdata,
  reg_bus_if.decoder  bus
);

  logic    accept;
  logic    dp_write;
  logic    dp_read;
  reg_op_e dp_idx;

  // NONSEQ or SEQ with the bus ready, word access only
  assign accept = hsel && htrans[1] && hready;

  // --------------------------------------------------------------------------
  // Address phase capture
  // --------------------------------------------------------------------------
  always_ff @(posedge master_clk) begin
    if (!rst_n) begin
      dp_write <= 1'b0;
      dp_read  <= 1'b0;
    end else begin
      dp_write <= accept && hwrite;
      dp_read  <= accept && !hwrite;
    end
  end

  // Index only matters when one of the phase flags is set
  always_ff @(posedge master_clk) begin
    if (accept) begin
      dp_idx <= reg_op_e'(haddr[4:2]);
    end
  end

  // --------------------------------------------------------------------------
  // Data phase strobes
  // --------------------------------------------------------------------------
  assign bus.wr_en   = dp_write;
  assign bus.wr_idx  = dp_idx;
  assign bus.wr_data = hwdata;

  // Idle or write data phase points at a hole in the map, reads as 0
  assign bus.rd_idx = dp_read ? dp_idx : reg_none;

endmodule

/* verilog/pctrl_ctrl_regs.sv */
/*
 * Platform controller register block
 * Gate, system-reset enable, clock select and reset request registers
 */
`timescale 1ns/1ps

module pctrl_ctrl_regs import pctrl_pkg::*; (
  input  logic    master_clk,
  input  logic    rst_n,
  reg_bus_if.regs bus,
  chan_ctrl_if.ctrl chan
);

  chan_mask_t gate_r;
  chan_mask_t sys_rst_en_r;
  chan_sel_t  clk_sel_r;
  logic       wr_rst_req;

  // --------------------------------------------------------------------------
  // Writable registers
  // --------------------------------------------------------------------------
  always_ff @(posedge master_clk) begin
    if (!rst_n) begin
      // Everything clocked and reset-followed out of reset
      gate_r       <= '1;
      sys_rst_en_r <= '1;
      clk_sel_r    <= '0;
    end else if (bus.wr_en) begin
      case (bus.wr_idx)
        reg_clk_gate:   gate_r       <= bus.wr_data[num_chan-1:0];
        reg_sys_rst_en: sys_rst_en_r <= bus.wr_data[num_chan-1:0];
        reg_clk_sel:    clk_sel_r    <= chan_sel_t'(bus.wr_data[num_chan*sel_w-1:0]);
        default: ;
      endcase
    end
  end

  // Write-one request, lasts only the data phase
  assign wr_rst_req = bus.wr_en && (bus.wr_idx == reg_rst_req);
  assign chan.rst_req_pulse = wr_rst_req ? bus.wr_data[num_chan-1:0] : '0;

  assign chan.gate_en    = gate_r;
  assign chan.sys_rst_en = sys_rst_en_r;
  assign chan.clk_sel    = clk_sel_r;

  // --------------------------------------------------------------------------
  // Read-back mux
  // --------------------------------------------------------------------------
  always_comb begin
    case (bus.rd_idx)
      reg_id:         bus.rd_data = pctrl_id_value;
      reg_clk_gate:   bus.rd_data = 32'(gate_r);
      reg_sys_rst_en: bus.rd_data = 32'(sys_rst_en_r);
      // Status view: channels still held in reset
      reg_rst_req:    bus.rd_data = 32'(chan.busy);
      reg_clk_sel:    bus.rd_data = 32'(clk_sel_r);
      default:        bus.rd_data = '0;
    endcase
  end

endmodule

/* verilog/pctrl_clken_gen.sv */
/*
 * Peripheral clock qualifiers
 * One shared prescaler, a pulse every 2^sel cycles per gated channel
 */
`timescale 1ns/1ps

module pctrl_clken_gen import pctrl_pkg::*; (
  input  logic          master_clk,
  input  logic          rst_n,
  chan_ctrl_if.clk_side chan,
  output chan_mask_t    clken
);

  logic [prescale_w-1:0] prescale;
  chan_mask_t            clken_r;

  // Low sel bits set, e.g. sel 3 gives 0000111
  function automatic logic [prescale_w-1:0] sel_mask(input logic [sel_w-1:0] sel);
    logic [prescale_w:0] full;
    full = ({{prescale_w{1'b0}}, 1'b1} << sel) - 1'b1;
    return full[prescale_w-1:0];
  endfunction

  always_ff @(posedge master_clk) begin
    if (!rst_n) begin
      prescale <= '0;
      clken_r  <= '0;
    end else begin
      // Free running, wraps every 128 cycles
      prescale <= prescale + 1'b1;
      for (int i = 0; i < num_chan; i++) begin
        clken_r[i] <= chan.gate_en[i] && (&(prescale | ~sel_mask(chan.clk_sel[i])));
      end
    end
  end

  assign clken = clken_r;

endmodule

/* verilog/pctrl_reset_seq.sv */
/*
 * Peripheral reset sequencer
 * Stretches system and software reset causes per channel
 */
`timescale 1ns/1ps

module pctrl_reset_seq import pctrl_pkg::*; (
  input  logic          master_clk,
  input  logic          rst_n,
  input  logic          sys_reset_req,
  chan_ctrl_if.rst_side chan,
  output chan_mask_t    resetn
);

  chan_mask_t            sys_cause;
  chan_mask_t            hold_zero;
  logic [hold_cnt_w-1:0] hold_cnt [num_chan];

  // Only channels that follow the system reset
  assign sys_cause = sys_reset_req ? chan.sys_rst_en : '0;

  // --------------------------------------------------------------------------
  // Hold counters
  // --------------------------------------------------------------------------
  always_ff @(posedge master_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_chan; i++) begin
        hold_cnt[i] <= hold_cnt_w'(reset_hold_cycles);
      end
    end else begin
      for (int i = 0; i < num_chan; i++) begin
        if (sys_cause[i] || chan.rst_req_pulse[i]) begin
          hold_cnt[i] <= hold_cnt_w'(reset_hold_cycles);
        end else if (hold_cnt[i] != '0) begin
          hold_cnt[i] <= hold_cnt[i] - 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < num_chan; i++) begin
      hold_zero[i] = (hold_cnt[i] == '0);
    end
  end

  // System request pulls reset low in the same cycle, hold follows
  assign resetn    = hold_zero & ~sys_cause;
  assign chan.busy = ~resetn;

endmodule

/* verilog/aha_platform_ctrl.sv */
/*
 * Platform controller top level
 * AHB-Lite register space driving peripheral qualifiers and resets
 */
`timescale 1ns/1ps

module aha_platform_ctrl import pctrl_pkg::*; (
  input  logic                master_clk,
  input  logic                rst_n,
  // AHB-Lite slave port
  input  logic                hsel,
  input  logic [31:0]         haddr,
  input  logic [1:0]          htrans,
  input  logic                hwrite,
  input  logic                hready,
  input  logic [31:0]         hwdata,
  output logic [31:0]         hrdata,
  output logic                hreadyout,
  output logic [1:0]          hresp,
  // Peripheral side
  input  logic                sys_reset_req,
  output logic [num_chan-1:0] periph_clken,
  output logic [num_chan-1:0] periph_resetn
);

  reg_bus_if   reg_bus ();
  chan_ctrl_if chan_ctrl ();

  pctrl_bus_decode u_bus_decode (
    .master_clk (master_clk),
    .rst_n      (rst_n),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hready     (hready),
    .hwdata     (hwdata),
    .bus        (reg_bus.decoder)
  );

  pctrl_ctrl_regs u_ctrl_regs (
    .master_clk (master_clk),
    .rst_n      (rst_n),
    .bus        (reg_bus.regs),
    .chan       (chan_ctrl.ctrl)
  );

  pctrl_clken_gen u_clken_gen (
    .master_clk (master_clk),
    .rst_n      (rst_n),
    .chan       (chan_ctrl.clk_side),
    .clken      (periph_clken)
  );

  pctrl_reset_seq u_reset_seq (
    .master_clk    (master_clk),
    .rst_n         (rst_n),
    .sys_reset_req (sys_reset_req),
    .chan          (chan_ctrl.rst_side),
    .resetn        (periph_resetn)
  );

  // Zero wait states, never an error response
  assign hreadyout = 1'b1;
  assign hresp     = hresp_okay;
  assign hrdata    = reg_bus.rd_data;

endmodule

/* tests/pctrl_assert.sv */
/*
 * Concurrent checks on the platform controller outputs
 */
`timescale 1ns/1ps

module pctrl_assert import pctrl_pkg::*; (
  input logic       master_clk,
  input logic       rst_n,
  input logic       hreadyout,
  input logic [1:0] hresp,
  input logic       sys_reset_req,
  input chan_mask_t gate_en,
  input chan_mask_t sys_rst_en,
  input chan_mask_t periph_clken,
  input chan_mask_t periph_resetn
);

  // Zero wait state slave, OKAY on every cycle
  bus_always_ready: assert property (@(posedge master_clk)
    hreadyout && (hresp == hresp_okay))
    else $error("hreadyout low or hresp not OKAY");

  // Qualifier is registered, so it follows the gate of the previous cycle
  clken_gated: assert property (@(posedge master_clk) disable iff (!rst_n)
    (periph_clken & ~$past(gate_en)) == '0)
    else $error("clken pulse on a gated channel");

  // Enabled channels drop in the same cycle as the system request
  sys_reset_follow: assert property (@(posedge master_clk) disable iff (!rst_n)
    (periph_resetn & sys_rst_en & {num_chan{sys_reset_req}}) == '0)
    else $error("resetn high during an enabled system reset request");

endmodule

bind aha_platform_ctrl pctrl_assert assert_inst (
  .master_clk    (master_clk),
  .rst_n         (rst_n),
  .hreadyout     (hreadyout),
  .hresp         (hresp),
  .sys_reset_req (sys_reset_req),
  .gate_en       (chan_ctrl.gate_en),
  .sys_rst_en    (chan_ctrl.sys_rst_en),
  .periph_clken  (periph_clken),
  .periph_resetn (periph_resetn)
);

/* tests/pctrl_tb.sv */
/*
 * Platform controller testbench
 * Replays the trace file against the AHB port and the peripheral outputs
 */
`timescale 1ns/1ps

module pctrl_tb import pctrl_pkg::*; ();

  logic        master_clk;
  logic        rst_n;
  logic        hsel;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic        hwrite;
  logic        hready;
  logic [31:0] hwdata;
  logic [31:0] hrdata;
  logic        hreadyout;
  logic [1:0]  hresp;
  logic        sys_reset_req;
  chan_mask_t  periph_clken;
  chan_mask_t  periph_resetn;
  int          errors;

  aha_platform_ctrl aha_platform_ctrl_inst (.*);

  initial begin
    master_clk = 1'b0;
    forever #4 master_clk = ~master_clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  // --------------------------------------------------------------------------
  // AHB-Lite transfers
  // --------------------------------------------------------------------------
  // Address phase, then data phase; read data sampled mid data phase
  task automatic ahb_xfer(input logic write, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge master_clk);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= 2'b10;
    hwrite <= write;
    @(posedge master_clk);
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwrite <= 1'b0;
    hwdata <= wdata;
    @(negedge master_clk);
    rdata = hrdata;
    // Zero wait states and an OKAY response in every data phase
    check_value("hreadyout data phase", 1, 32'(hreadyout));
    check_value("hresp data phase", 0, 32'(hresp));
    @(posedge master_clk);
  endtask

  // Pulses of one qualifier over a full prescaler period
  task automatic clken_rate(input int ch, input logic [sel_w-1:0] sel,
                            input logic [31:0] expected);
    logic [31:0] sel_reg;
    int          pulses;
    ahb_xfer(1'b0, 32'h10, '0, sel_reg);
    sel_reg[ch*sel_w +: sel_w] = sel;
    ahb_xfer(1'b1, 32'h10, sel_reg, sel_reg);
    // New select reaches the registered qualifier within a few cycles
    repeat (4) @(posedge master_clk);
    pulses = 0;
    repeat (128) begin
      @(negedge master_clk);
      pulses += int'(periph_clken[ch]);
    end
    check_value($sformatf("clken ch%0d sel %0d", ch, sel), expected, pulses);
  endtask

  // Reset request through the register, low time and busy status side by side
  task automatic soft_reset(input chan_mask_t mask, input logic [31:0] expected);
    logic [31:0] status;
    chan_mask_t  others_low;
    int          low_cycles;
    int          polls;
    ahb_xfer(1'b1, 32'h0c, 32'(mask), status);
    low_cycles = 0;
    others_low = '0;
    fork
      begin
        @(negedge master_clk);
        check_value("soft reset start", 32'(mask), 32'(mask & ~periph_resetn));
        for (int t = 0; t < 64 && (periph_resetn & mask) != mask; t++) begin
          low_cycles++;
          others_low |= ~mask & ~periph_resetn;
          @(negedge master_clk);
        end
        if ((periph_resetn & mask) != mask) report_failure("timeout: software reset held");
        check_value("soft reset low cycles", expected, low_cycles);
        check_value("soft reset other channels", 0, 32'(others_low));
      end
      begin
        ahb_xfer(1'b0, 32'h0c, '0, status);
        check_value("soft reset busy", 32'(mask), status);
        for (polls = 0; polls < 32 && status != 0; polls++) begin
          ahb_xfer(1'b0, 32'h0c, '0, status);
        end
        if (status != 0) report_failure("timeout: reset busy status never cleared");
      end
    join
  endtask

  // System reset request for len cycles, low time counted per channel
  task automatic sys_reset_pulse(input int len, input chan_mask_t expected_mask);
    int   low_cycles [num_chan];
    logic pulse_done;
    int   t;
    foreach (low_cycles[i]) begin
      low_cycles[i] = 0;
    end
    pulse_done = 1'b0;
    fork
      begin
        @(posedge master_clk);
        sys_reset_req <= 1'b1;
        repeat (len) @(posedge master_clk);
        sys_reset_req <= 1'b0;
        pulse_done = 1'b1;
      end
      begin
        for (t = 0; t < 128 && !(pulse_done && periph_resetn == '1); t++) begin
          @(negedge master_clk);
          for (int i = 0; i < num_chan; i++) begin
            low_cycles[i] += int'(!periph_resetn[i]);
          end
        end
      end
    join
    if (periph_resetn != '1) report_failure("timeout: system reset never released");
    for (int i = 0; i < num_chan; i++) begin
      check_value($sformatf("sys reset low cycles ch%0d", i),
                  expected_mask[i] ? len + reset_hold_cycles : 0, low_cycles[i]);
    end
  endtask

  // --------------------------------------------------------------------------
  // Reset and trace replay
  // --------------------------------------------------------------------------
  initial begin
    int          fd;
    string       line;
    byte         op;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    logic [31:0] arg_c;
    logic [31:0] rd;
    errors = 0;
    void'($urandom(16));
    rst_n         = 1'b0;
    hsel          = 1'b0;
    haddr         = '0;
    htrans        = 2'b00;
    hwrite        = 1'b0;
    hready        = 1'b1;
    hwdata        = '0;
    sys_reset_req = 1'b0;
    repeat (15) @(posedge master_clk);
    @(negedge master_clk);
    check_value("clken in reset", 0, 32'(periph_clken));
    check_value("resetn in reset", 0, 32'(periph_resetn));
    check_value("hrdata in reset", 0, hrdata);
    check_value("hreadyout in reset", 1, 32'(hreadyout));
    @(posedge master_clk);
    rst_n <= 1'b1;
    // Peripheral resets stay stretched for a while after rst_n rises
    for (int t = 0; t < 64 && periph_resetn != '1; t++) begin
      @(negedge master_clk);
    end
    if (periph_resetn != '1) report_failure("timeout: peripheral resets stuck after rst_n");
    fd = $fopen("tests/pctrl_trace.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open tests/pctrl_trace.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        op = "#";
        void'($sscanf(line, "%c %h %h %h", op, arg_a, arg_b, arg_c));
        case (op)
          "W": ahb_xfer(1'b1, arg_a, arg_b, rd);
          "R": begin
            ahb_xfer(1'b0, arg_a, '0, rd);
            check_value($sformatf("read %h", arg_a), arg_b, rd);
          end
          "K": clken_rate(int'(arg_a), arg_b[sel_w-1:0], arg_c);
          "P": soft_reset(arg_a[num_chan-1:0], arg_b);
          "S": sys_reset_pulse(int'(arg_a), arg_b[num_chan-1:0]);
          default: ;
        endcase
        // Idle gap between operations
        repeat ($urandom % 4) @(posedge master_clk);
      end
      $fclose(fd);
    end
    $display("Total errors: %0d", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* tests/pctrl_trace.txt */
# op W addr data | R addr expected | K chan sel pulses_in_128
# op P chan_mask low_cycles | S pulse_cycles low_mask, all values hex
R 00000000 50430001
R 00000004 0000000f
R 00000008 0000000f
R 0000000c 00000000
R 00000010 00000000
R 0000001c 00000000
W 00000004 00000005
W 00000010 00000abc
W 00000000 12345678
W 00000018 ffffffff
R 00000004 00000005
R 00000010 00000abc
R 00000000 50430001
K 0 4 8
K 2 2 20
K 1 7 0
W 00000004 0000000f
K 3 5 4
K 0 0 80
P 5 8
W 00000008 00000006
S 3 6

/* sources.f */
verilog/pctrl_pkg.sv
verilog/pctrl_if.sv
verilog/pctrl_bus_decode.sv
verilog/pctrl_ctrl_regs.sv
verilog/pctrl_clken_gen.sv
verilog/pctrl_reset_seq.sv
verilog/aha_platform_ctrl.sv
tests/pctrl_assert.sv
tests/pctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the platform controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module pctrl_tb

# Result is judged from the log, so a failing run must not stop the script here
./obj_dir/Vpctrl_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
